//--- include/axil_consts.svh
`ifndef AXIL_CONSTS_SVH
`define AXIL_CONSTS_SVH

// Bus widths in bits
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// Number of 32-bit registers in the slave bank
`define AXIL_REG_COUNT 16

// Cycles from request acceptance to BVALID or RVALID
`define AXIL_SLAVE_WAIT 3

`endif

//--- hw/axil_pkg.sv
`include "axil_consts.svh"

package axil_pkg;

   typedef logic [`AXIL_DATA_W-1:0] word_t;   // One data word
   typedef logic [`AXIL_ADDR_W-1:0] addr_t;   // Byte address
   typedef logic [`AXIL_STRB_W-1:0] strb_t;   // One strobe per byte lane

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } resp_t;

   typedef enum logic [3:0] {
      ST_IDLE     = 4'd0,
      ST_WA_START = 4'd1,
      ST_WA_WAIT  = 4'd2,
      ST_WD       = 4'd3,
      ST_WR_WAIT  = 4'd4,
      ST_RA_START = 4'd5,
      ST_RA_WAIT  = 4'd6,
      ST_RD       = 4'd7,
      ST_FIN      = 4'd8
   } bridge_state_t;

endpackage

//--- hw/axil_wait_timer.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_wait_timer #(
   parameter int WAIT = `AXIL_SLAVE_WAIT
) (
   input  logic CLK,
   input  logic RST_N,
   input  logic start,
   output logic done
);

   localparam int CNT_W = $clog2(WAIT + 1);

   logic [CNT_W-1:0] cnt;
   logic             busy;

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         cnt  <= '0;
         busy <= 1'b0;
      end else if (busy) begin
         cnt <= cnt - 1'b1;
         if (cnt == CNT_W'(1)) begin
            busy <= 1'b0;
         end
      end else if (start) begin
         cnt  <= CNT_W'(WAIT);   // A start while busy is dropped
         busy <= 1'b1;
      end
   end

   // Fires WAIT cycles after the start pulse
   assign done = busy && (cnt == CNT_W'(1));

endmodule

//--- hw/axil_master_fsm.sv
`timescale 1ns/1ps

module axil_master_fsm (
   input  logic          CLK,
   input  logic          RST_N,
   input  logic          bus_ena,
   input  axil_pkg::strb_t bus_wstb,
   input  logic          awready,
   input  logic          wready,
   input  logic          bvalid,
   input  logic          arready,
   input  logic          rvalid,
   output logic          awvalid,
   output logic          wvalid,
   output logic          bready,
   output logic          arvalid,
   output logic          rready,
   output logic          bus_wait,
   output logic          capture_req,
   output logic          capture_resp,
   output logic          clear_err
);

   axil_pkg::bridge_state_t state;
   axil_pkg::bridge_state_t next_state;

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         state <= axil_pkg::ST_IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         axil_pkg::ST_IDLE: begin
            if (bus_ena) begin
               // Any strobe set selects the write path
               if (|bus_wstb) begin
                  next_state = axil_pkg::ST_WA_START;
               end else begin
                  next_state = axil_pkg::ST_RA_START;
               end
            end
         end
         axil_pkg::ST_WA_START: begin
            next_state = axil_pkg::ST_WA_WAIT;
         end
         axil_pkg::ST_WA_WAIT: begin
            if (awready) begin
               next_state = axil_pkg::ST_WD;
            end
         end
         axil_pkg::ST_WD: begin
            if (wready) begin
               next_state = axil_pkg::ST_WR_WAIT;
            end
         end
         axil_pkg::ST_WR_WAIT: begin
            if (bvalid) begin
               next_state = axil_pkg::ST_FIN;
            end
         end
         axil_pkg::ST_RA_START: begin
            next_state = axil_pkg::ST_RA_WAIT;
         end
         axil_pkg::ST_RA_WAIT: begin
            if (arready) begin
               next_state = axil_pkg::ST_RD;
            end
         end
         axil_pkg::ST_RD: begin
            if (rvalid) begin
               next_state = axil_pkg::ST_FIN;
            end
         end
         axil_pkg::ST_FIN: begin
            next_state = axil_pkg::ST_IDLE;
         end
         default: begin
            next_state = axil_pkg::ST_IDLE;
         end
      endcase
   end

   // Channel valids are decoded from the registered state, so they stay up until ready
   assign awvalid = (state == axil_pkg::ST_WA_WAIT);
   assign wvalid  = (state == axil_pkg::ST_WD);
   assign bready  = (state == axil_pkg::ST_WR_WAIT);
   assign arvalid = (state == axil_pkg::ST_RA_WAIT);
   assign rready  = 1'b1;

   assign capture_req  = (state == axil_pkg::ST_IDLE) && bus_ena;
   assign clear_err    = capture_req;
   assign capture_resp = ((state == axil_pkg::ST_WR_WAIT) && bvalid) ||
                         ((state == axil_pkg::ST_RD) && rvalid && rready);

   assign bus_wait = (state != axil_pkg::ST_FIN);   // Low for the single finish cycle

endmodule

//--- hw/axil_req_latch.sv
`timescale 1ns/1ps

module axil_req_latch (
   input  logic            CLK,
   input  logic            RST_N,
   input  logic            capture_req,
   input  logic            capture_resp,
   input  logic            clear_err,
   input  logic            req_is_read,
   input  axil_pkg::addr_t bus_addr,
   input  axil_pkg::strb_t bus_wstb,
   input  axil_pkg::word_t bus_wdata,
   input  axil_pkg::word_t rdata,
   input  axil_pkg::resp_t resp,
   output axil_pkg::addr_t axi_addr,
   output axil_pkg::strb_t axi_wstrb,
   output axil_pkg::word_t axi_wdata,
   output axil_pkg::word_t bus_rdata,
   output logic            bus_err
);

   // The caller may change its inputs once the request is taken
   always_ff @(posedge CLK) begin
      if (capture_req) begin
         axi_addr  <= bus_addr;
         axi_wstrb <= bus_wstb;
         axi_wdata <= bus_wdata;
      end
   end

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         bus_rdata <= '0;
         bus_err   <= 1'b0;
      end else begin
         if (clear_err) begin
            bus_err <= 1'b0;
         end else if (capture_resp) begin
            bus_err <= (resp != axil_pkg::RESP_OKAY);
         end
         if (capture_resp && req_is_read) begin
            bus_rdata <= rdata;   // Writes leave the last read word in place
         end
      end
   end

endmodule

//--- hw/axil_reg_slave.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_reg_slave (
   input  logic            CLK,
   input  logic            RST_N,
   input  axil_pkg::addr_t awaddr,
   input  logic            awvalid,
   input  logic            wvalid,
   input  logic            bready,
   input  logic            arvalid,
   input  logic            rready,
   input  axil_pkg::word_t wdata,
   input  axil_pkg::strb_t wstrb,
   input  axil_pkg::addr_t araddr,
   output logic            awready,
   output logic            wready,
   output logic            bvalid,
   output logic            arready,
   output logic            rvalid,
   output axil_pkg::resp_t bresp,
   output axil_pkg::word_t rdata,
   output axil_pkg::resp_t rresp
);

   localparam int IDX_W = $clog2(`AXIL_REG_COUNT);

   axil_pkg::word_t  regs [`AXIL_REG_COUNT];
   logic [IDX_W-1:0] aw_idx;
   logic             aw_oor;
   logic             aw_hs;
   logic             w_hs;
   logic             ar_hs;
   logic             ar_oor;
   logic             pend_read;
   logic             timer_done;

   assign aw_hs = awvalid && awready;
   assign w_hs  = wvalid && wready;
   assign ar_hs = arvalid && arready;

   // Word index sits above the two byte offset bits
   assign ar_oor = (araddr[`AXIL_ADDR_W-1:2] >= (`AXIL_ADDR_W-2)'(`AXIL_REG_COUNT));

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         awready   <= 1'b0;
         wready    <= 1'b0;
         arready   <= 1'b0;
         bvalid    <= 1'b0;
         rvalid    <= 1'b0;
         pend_read <= 1'b0;
      end else begin
         awready <= awvalid && !awready;   // One-cycle ready after valid is seen
         wready  <= wvalid && !wready;
         arready <= arvalid && !arready;
         if (w_hs || ar_hs) begin
            pend_read <= ar_hs;
         end
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end else if (timer_done && !pend_read) begin
            bvalid <= 1'b1;
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end else if (timer_done && pend_read) begin
            rvalid <= 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (aw_hs) begin
         aw_idx <= awaddr[IDX_W+1:2];
         aw_oor <= (awaddr[`AXIL_ADDR_W-1:2] >= (`AXIL_ADDR_W-2)'(`AXIL_REG_COUNT));
      end
      if (w_hs) begin
         bresp <= aw_oor ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
      end
      if (ar_hs) begin
         rdata <= ar_oor ? '0 : regs[araddr[IDX_W+1:2]];
         rresp <= ar_oor ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
      end
   end

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (w_hs && !aw_oor) begin
         for (int b = 0; b < `AXIL_STRB_W; b++) begin
            if (wstrb[b]) begin
               regs[aw_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
      end
   end

   axil_wait_timer #(
      .WAIT(`AXIL_SLAVE_WAIT)
   ) u_timer (
      .CLK  (CLK),
      .RST_N(RST_N),
      .start(w_hs || ar_hs),
      .done (timer_done)
   );

endmodule

//--- hw/axil_bridge_top.sv
`timescale 1ns/1ps

module axil_bridge_top (
   input  logic            CLK,
   input  logic            RST_N,
   input  logic            bus_ena,
   input  axil_pkg::strb_t bus_wstb,
   input  axil_pkg::addr_t bus_addr,
   input  axil_pkg::word_t bus_wdata,
   output logic            bus_wait,
   output axil_pkg::word_t bus_rdata,
   output logic            bus_err
);

   logic            awvalid, awready, wvalid, wready, bvalid, bready;
   logic            arvalid, arready, rvalid, rready;
   logic            capture_req, capture_resp, clear_err, req_is_read;
   axil_pkg::addr_t axi_addr;
   axil_pkg::strb_t axi_wstrb;
   axil_pkg::word_t axi_wdata, rdata;
   axil_pkg::resp_t bresp, rresp, resp_sel;

   // Only one channel can be returning a response at a time
   assign resp_sel    = rvalid ? rresp : bresp;
   assign req_is_read = rvalid && rready;

   axil_master_fsm u_fsm (
      .CLK(CLK), .RST_N(RST_N), .bus_ena(bus_ena), .bus_wstb(bus_wstb),
      .awready(awready), .wready(wready), .bvalid(bvalid), .arready(arready),
      .rvalid(rvalid), .awvalid(awvalid), .wvalid(wvalid), .bready(bready),
      .arvalid(arvalid), .rready(rready), .bus_wait(bus_wait),
      .capture_req(capture_req), .capture_resp(capture_resp), .clear_err(clear_err)
   );

   axil_req_latch u_latch (
      .CLK(CLK), .RST_N(RST_N), .capture_req(capture_req),
      .capture_resp(capture_resp), .clear_err(clear_err), .req_is_read(req_is_read),
      .bus_addr(bus_addr), .bus_wstb(bus_wstb), .bus_wdata(bus_wdata),
      .rdata(rdata), .resp(resp_sel), .axi_addr(axi_addr), .axi_wstrb(axi_wstrb),
      .axi_wdata(axi_wdata), .bus_rdata(bus_rdata), .bus_err(bus_err)
   );

   axil_reg_slave u_slave (
      .CLK(CLK), .RST_N(RST_N), .awaddr(axi_addr), .awvalid(awvalid),
      .wvalid(wvalid), .bready(bready), .arvalid(arvalid), .rready(rready),
      .wdata(axi_wdata), .wstrb(axi_wstrb), .araddr(axi_addr), .awready(awready),
      .wready(wready), .bvalid(bvalid), .arready(arready), .rvalid(rvalid),
      .bresp(bresp), .rdata(rdata), .rresp(rresp)
   );

endmodule

//--- test/tb_axil_bridge.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module tb_axil_bridge;

   localparam int RESET_CYCLES = 4;
   localparam int TBL_MAX      = 64;

   logic            CLK;
   logic            RST_N;
   logic            bus_ena;
   axil_pkg::strb_t bus_wstb;
   axil_pkg::addr_t bus_addr;
   axil_pkg::word_t bus_wdata;
   logic            bus_wait;
   axil_pkg::word_t bus_rdata;
   logic            bus_err;

   logic            tbl_write [TBL_MAX];   // One row per transfer
   axil_pkg::addr_t tbl_addr  [TBL_MAX];
   axil_pkg::strb_t tbl_strb  [TBL_MAX];
   axil_pkg::word_t tbl_wdata [TBL_MAX];
   axil_pkg::word_t tbl_rdata [TBL_MAX];
   logic            tbl_err   [TBL_MAX];
   int              tbl_len;

   axil_pkg::word_t model [`AXIL_REG_COUNT];   // Expected contents of the register bank
   int              seed;
   int              err_cnt;
   int              cycle_cnt;
   int              cycle_limit;

   axil_bridge_top DUT (
      .CLK(CLK), .RST_N(RST_N), .bus_ena(bus_ena), .bus_wstb(bus_wstb),
      .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_wait(bus_wait),
      .bus_rdata(bus_rdata), .bus_err(bus_err)
   );

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   always @(posedge CLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Run hung: no done cycle within %0d cycles, %0d errors", cycle_cnt, err_cnt);
         $display("Test failed");
         $finish;
      end
   end

   function automatic axil_pkg::word_t rand_word();
      return $random(seed);
   endfunction

   task automatic check_word(input string name, input axil_pkg::word_t got,
                             input axil_pkg::word_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         err_cnt++;
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         err_cnt++;
      end
   endtask

   task automatic put_entry(input logic wr, input axil_pkg::addr_t addr,
                            input axil_pkg::strb_t strb, input axil_pkg::word_t wdata,
                            input axil_pkg::word_t rdata, input logic err);
      if (tbl_len >= TBL_MAX) begin
         $display("Stimulus table is full, a transfer was dropped");
         err_cnt++;
      end else begin
         tbl_write[tbl_len] = wr;
         tbl_addr[tbl_len]  = addr;
         tbl_strb[tbl_len]  = strb;
         tbl_wdata[tbl_len] = wdata;
         tbl_rdata[tbl_len] = rdata;
         tbl_err[tbl_len]   = err;
         tbl_len++;
      end
   endtask

   // Word index is the byte address without its two offset bits
   task automatic add_write(input axil_pkg::addr_t addr, input axil_pkg::strb_t strb,
                            input axil_pkg::word_t data);
      int   idx;
      logic oor;
      idx = int'(addr[`AXIL_ADDR_W-1:2]);
      oor = (idx >= `AXIL_REG_COUNT);
      if (!oor) begin
         for (int b = 0; b < `AXIL_STRB_W; b++) begin
            if (strb[b]) begin
               model[idx][8*b +: 8] = data[8*b +: 8];
            end
         end
      end
      put_entry(1'b1, addr, strb, data, '0, oor);
   endtask

   task automatic add_read(input axil_pkg::addr_t addr);
      int              idx;
      logic            oor;
      axil_pkg::word_t exp;
      idx = int'(addr[`AXIL_ADDR_W-1:2]);
      oor = (idx >= `AXIL_REG_COUNT);
      exp = '0;
      if (!oor) begin
         exp = model[idx];
      end
      put_entry(1'b0, addr, '0, '0, exp, oor);
   endtask

   task automatic build_table();
      for (int r = 0; r < `AXIL_REG_COUNT; r++) begin
         model[r] = '0;
      end
      add_read(32'h0000_0000);   // Registers come out of reset as zero
      add_read(32'h0000_0014);
      add_read(32'h0000_003C);
      add_write(32'h0000_000C, 4'hF, rand_word());
      add_read(32'h0000_000C);
      add_write(32'h0000_001C, 4'hF, rand_word());   // Lane merges on one register
      add_write(32'h0000_001C, 4'b0001, rand_word());
      add_read(32'h0000_001C);
      add_write(32'h0000_001C, 4'b0100, rand_word());
      add_read(32'h0000_001C);
      add_write(32'h0000_001C, 4'b1010, rand_word());
      add_read(32'h0000_001C);
      add_write(32'h0000_0040, 4'hF, rand_word());   // Index 16 would alias register 0
      add_write(32'h0000_0004, 4'b0011, rand_word());
      add_read(32'h0000_0040);
      add_read(32'h0000_101C);   // Low index bits alone would select register 7
      add_read(32'h0000_0000);
      add_read(32'h0000_0004);
      for (int r = 0; r < `AXIL_REG_COUNT; r++) begin
         add_write(axil_pkg::addr_t'(r * 4), 4'hF, rand_word());
      end
      for (int r = 0; r < `AXIL_REG_COUNT; r++) begin
         add_read(axil_pkg::addr_t'(r * 4));
      end
   endtask

   task automatic run_entry(input int i);
      @(posedge CLK);
      bus_ena   <= 1'b1;
      bus_wstb  <= tbl_write[i] ? tbl_strb[i] : '0;
      bus_addr  <= tbl_addr[i];
      bus_wdata <= tbl_wdata[i];
      @(posedge CLK);
      bus_wdata <= ~tbl_wdata[i];   // Request was taken at this edge
      @(negedge CLK);
      while (bus_wait) begin
         @(negedge CLK);
      end
      if (!tbl_write[i]) begin
         check_word("bus_rdata", bus_rdata, tbl_rdata[i]);
      end
      check_err("bus_err", bus_err, tbl_err[i]);
      @(posedge CLK);
      bus_ena <= 1'b0;
      @(negedge CLK);
      check_err("bus_wait", bus_wait, 1'b1);   // Done lasts a single cycle
   endtask

   initial begin
      seed      = 32'h6b5c;
      err_cnt   = 0;
      tbl_len   = 0;
      cycle_cnt = 0;
      RST_N     = 1'b0;
      bus_ena   = 1'b0;
      bus_wstb  = '0;
      bus_addr  = '0;
      bus_wdata = '0;
      build_table();
      cycle_limit = tbl_len * (`AXIL_SLAVE_WAIT + 12) + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge CLK);
      RST_N <= 1'b1;
      @(negedge CLK);
      check_err("bus_wait", bus_wait, 1'b1);
      check_err("bus_err", bus_err, 1'b0);
      check_word("bus_rdata", bus_rdata, '0);
      for (int i = 0; i < tbl_len; i++) begin
         run_entry(i);
      end
      $display("Ran %0d transfers, %0d errors", tbl_len, err_cnt);
      if (err_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- axil_bridge_top.f
+incdir+include
hw/axil_pkg.sv
hw/axil_wait_timer.sv
hw/axil_master_fsm.sv
hw/axil_req_latch.sv
hw/axil_reg_slave.sv
hw/axil_bridge_top.sv
test/tb_axil_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axil_bridge
FILELIST  ?= axil_bridge_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuild only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
